//--- common/deu_isa_pkg.sv
package deu_isa_pkg;

    localparam int INST_W  = 32;
    localparam int PC_W    = 64;
    localparam int ARF_SEL = 5;

    ////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////

    localparam int RD_LSB  = 0;
    localparam int RJ_LSB  = 5;
    localparam int RK_LSB  = 10;
    localparam int IMM_LSB = 10;
    localparam int IMM_W   = 12;  // Sign-extended
    localparam int OPC_LSB = 26;
    localparam int OPC_W   = 6;

    // Major opcodes, anything else decodes as OP_NOP
    typedef enum logic [OPC_W-1:0] {
        OP_NOP    = 6'd0,
        OP_ALU_RR = 6'd1,   // rj, rk
        OP_ALU_RI = 6'd2,   // rj, imm12
        OP_LINK   = 6'd3,   // pc, 4
        OP_PCREL  = 6'd4    // pc, imm12
    } deu_op_e;

    // Return address step for OP_LINK
    localparam int LINK_OFFSET = 4;

endpackage

//--- common/deu_pipe_pkg.sv
package deu_pipe_pkg;

    localparam int LANES    = 2;
    localparam int IB_DEPTH = 4;

    // Result producers behind decode, youngest first
    typedef enum logic [2:0] {
        STG_EX1,
        STG_EX2,
        STG_EX3,
        STG_EX4,
        STG_WB
    } bypass_stage_e;

    localparam int NUM_BYPASS_STAGES = int'(STG_WB) + 1;

endpackage

//--- inst_queue/inst_queue.sv
`timescale 1ns/1ps

module inst_queue (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    issue_stall,
    input  logic                                                    ifu_i0_valid,
    input  logic [deu_isa_pkg::PC_W-1:0]                            ifu_i0_pc,
    input  logic [deu_isa_pkg::INST_W-1:0]                          ifu_i0_inst,
    input  logic                                                    ifu_i1_valid,
    input  logic [deu_isa_pkg::PC_W-1:0]                            ifu_i1_pc,
    input  logic [deu_isa_pkg::INST_W-1:0]                          ifu_i1_inst,
    output logic                                                    ib2_val,
    output logic                                                    ib3_val,
    output logic [deu_pipe_pkg::LANES-1:0]                          head_valid,
    output logic [deu_pipe_pkg::LANES-1:0][deu_isa_pkg::PC_W-1:0]   head_pc,
    output logic [deu_pipe_pkg::LANES-1:0][deu_isa_pkg::INST_W-1:0] head_inst
);

    localparam int DEPTH = deu_pipe_pkg::IB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [CNT_W-1:0]                   cnt;
    logic [CNT_W-1:0]                   cnt_nxt;
    logic [CNT_W-1:0]                   pop_n;
    logic [CNT_W-1:0]                   keep_n;
    logic [CNT_W-1:0]                   push_n;
    logic [deu_isa_pkg::PC_W-1:0]       pc_q    [DEPTH];
    logic [deu_isa_pkg::PC_W-1:0]       pc_d    [DEPTH];
    logic [deu_isa_pkg::INST_W-1:0]     inst_q  [DEPTH];
    logic [deu_isa_pkg::INST_W-1:0]     inst_d  [DEPTH];

    // Every valid head leaves unless the back end stalls
    always_comb begin
        pop_n = '0;
        if (!issue_stall) begin
            pop_n = (cnt >= CNT_W'(deu_pipe_pkg::LANES)) ? CNT_W'(deu_pipe_pkg::LANES) : cnt;
        end
        keep_n  = cnt - pop_n;
        push_n  = CNT_W'(ifu_i0_valid) + CNT_W'(ifu_i1_valid);
        cnt_nxt = keep_n + push_n;
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            pc_d[i]   = pc_q[i];
            inst_d[i] = inst_q[i];
            if (CNT_W'(i) < keep_n) begin       // Survivors shift down
                pc_d[i]   = pc_q[i + int'(pop_n)];
                inst_d[i] = inst_q[i + int'(pop_n)];
            end else if (CNT_W'(i) == keep_n) begin
                pc_d[i]   = ifu_i0_pc;
                inst_d[i] = ifu_i0_inst;
            end else if (CNT_W'(i) == keep_n + CNT_W'(1)) begin
                pc_d[i]   = ifu_i1_pc;
                inst_d[i] = ifu_i1_inst;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt_nxt;
        end
    end

    always_ff @(posedge clk) begin
        pc_q   <= pc_d;
        inst_q <= inst_d;
    end

    assign ib2_val = (cnt > CNT_W'(2));
    assign ib3_val = (cnt > CNT_W'(3));

    always_comb begin
        for (int l = 0; l < deu_pipe_pkg::LANES; l++) begin
            head_valid[l] = (cnt > CNT_W'(l));
            head_pc[l]    = pc_q[l];
            head_inst[l]  = inst_q[l];
        end
    end

    ////////////////////////////////////////////////
    // Fetch protocol
    ////////////////////////////////////////////////

    a_i1_needs_i0: assert property (@(posedge clk) disable iff (!rst_n)
        ifu_i1_valid |-> ifu_i0_valid);

    // A two-wide push needs entry 2 free, a single one entry 3
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        (ifu_i1_valid |-> !ib2_val) and (ifu_i0_valid |-> !ib3_val));

endmodule

//--- issue_lane/bypass_select.sv
`timescale 1ns/1ps

module bypass_select #(
    parameter int DATA_W        = 64,
    parameter int BYPASS_STAGES = 5
) (
    input  logic                                   rd_en,
    input  logic [deu_isa_pkg::ARF_SEL-1:0]        raddr,
    input  logic [DATA_W-1:0]                      rdata,
    input  logic [BYPASS_STAGES-1:0][deu_pipe_pkg::LANES-1:0] rf_we,
    input  logic [BYPASS_STAGES-1:0][deu_pipe_pkg::LANES-1:0][deu_isa_pkg::ARF_SEL-1:0] rf_waddr,
    input  logic [BYPASS_STAGES-1:0][deu_pipe_pkg::LANES-1:0][DATA_W-1:0] result,
    output logic [DATA_W-1:0]                      src
);

    localparam int LANES = deu_pipe_pkg::LANES;
    localparam int NPROD = BYPASS_STAGES * LANES;

    logic [NPROD-1:0]  hit;
    logic [NPROD-1:0]  sel;
    logic [DATA_W-1:0] byp_data;

    // Bit 0 is the youngest producer with the higher lane first in a stage
    always_comb begin
        for (int s = 0; s < BYPASS_STAGES; s++) begin
            for (int l = 0; l < LANES; l++) begin
                hit[s*LANES + LANES-1-l] = rd_en && rf_we[s][l] && (rf_waddr[s][l] == raddr);
            end
        end
    end

    assign sel = hit & (~hit + NPROD'(1));  // Lowest set bit wins

    always_comb begin
        byp_data = '0;
        for (int s = 0; s < BYPASS_STAGES; s++) begin
            for (int l = 0; l < LANES; l++) begin
                byp_data |= {DATA_W{sel[s*LANES + LANES-1-l]}} & result[s][l];
            end
        end
    end

    assign src = (|hit) ? byp_data : rdata;

    // r0 reads stay disabled so r0 never meets a producer
    always_comb begin
        a_no_r0_read: assert final (!rd_en || (raddr != '0));
    end

endmodule

//--- issue_lane/issue_lane.sv
`timescale 1ns/1ps

module issue_lane #(
    parameter int DATA_W        = 64,
    parameter int BYPASS_STAGES = 5
) (
    input  logic                                   head_valid,
    input  logic [deu_isa_pkg::PC_W-1:0]           head_pc,
    input  logic [deu_isa_pkg::INST_W-1:0]         head_inst,
    input  logic [DATA_W-1:0]                      rdata0,
    input  logic [DATA_W-1:0]                      rdata1,
    input  logic [BYPASS_STAGES-1:0][deu_pipe_pkg::LANES-1:0] rf_we,
    input  logic [BYPASS_STAGES-1:0][deu_pipe_pkg::LANES-1:0][deu_isa_pkg::ARF_SEL-1:0] rf_waddr,
    input  logic [BYPASS_STAGES-1:0][deu_pipe_pkg::LANES-1:0][DATA_W-1:0] result,
    output logic [deu_isa_pkg::ARF_SEL-1:0]        raddr0,
    output logic [deu_isa_pkg::ARF_SEL-1:0]        raddr1,
    output logic                                   dec_valid,
    output deu_isa_pkg::deu_op_e                   dec_op,
    output logic [deu_isa_pkg::PC_W-1:0]           dec_pc,
    output logic [DATA_W-1:0]                      src0,
    output logic [DATA_W-1:0]                      src1
);

    localparam int SEL_W = deu_isa_pkg::ARF_SEL;
    localparam int IMM_W = deu_isa_pkg::IMM_W;

    logic [SEL_W-1:0]  rj;
    logic [SEL_W-1:0]  rk;
    logic [IMM_W-1:0]  imm12;
    logic [DATA_W-1:0] imm;
    logic              rd_en0;
    logic              rd_en1;
    logic [DATA_W-1:0] opnd0;
    logic [DATA_W-1:0] opnd1;

    assign rj    = head_inst[deu_isa_pkg::RJ_LSB +: SEL_W];
    assign rk    = head_inst[deu_isa_pkg::RK_LSB +: SEL_W];
    assign imm12 = head_inst[deu_isa_pkg::IMM_LSB +: IMM_W];
    assign imm   = {{(DATA_W - IMM_W){imm12[IMM_W-1]}}, imm12};

    always_comb begin
        case (head_inst[deu_isa_pkg::OPC_LSB +: deu_isa_pkg::OPC_W])
            deu_isa_pkg::OP_ALU_RR: dec_op = deu_isa_pkg::OP_ALU_RR;
            deu_isa_pkg::OP_ALU_RI: dec_op = deu_isa_pkg::OP_ALU_RI;
            deu_isa_pkg::OP_LINK:   dec_op = deu_isa_pkg::OP_LINK;
            deu_isa_pkg::OP_PCREL:  dec_op = deu_isa_pkg::OP_PCREL;
            default:                dec_op = deu_isa_pkg::OP_NOP;
        endcase
    end

    // r0 and unused sources never read or bypass
    assign rd_en0 = (dec_op == deu_isa_pkg::OP_ALU_RR || dec_op == deu_isa_pkg::OP_ALU_RI)
                    && (rj != '0);
    assign rd_en1 = (dec_op == deu_isa_pkg::OP_ALU_RR) && (rk != '0);
    assign raddr0 = rd_en0 ? rj : '0;
    assign raddr1 = rd_en1 ? rk : '0;

    bypass_select #(.DATA_W(DATA_W), .BYPASS_STAGES(BYPASS_STAGES)) bypass_src0_i (
        .rd_en    (rd_en0),
        .raddr    (raddr0),
        .rdata    (rdata0),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .result   (result),
        .src      (opnd0)
    );

    bypass_select #(.DATA_W(DATA_W), .BYPASS_STAGES(BYPASS_STAGES)) bypass_src1_i (
        .rd_en    (rd_en1),
        .raddr    (raddr1),
        .rdata    (rdata1),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .result   (result),
        .src      (opnd1)
    );

    always_comb begin
        src0 = '0;
        src1 = '0;
        case (dec_op)
            deu_isa_pkg::OP_ALU_RR: begin
                src0 = opnd0;
                src1 = opnd1;
            end
            deu_isa_pkg::OP_ALU_RI: begin
                src0 = opnd0;
                src1 = imm;
            end
            deu_isa_pkg::OP_LINK: begin
                src0 = DATA_W'(head_pc);
                src1 = DATA_W'(deu_isa_pkg::LINK_OFFSET);
            end
            deu_isa_pkg::OP_PCREL: begin
                src0 = DATA_W'(head_pc);
                src1 = imm;
            end
            default: ;                          // NOP carries zeros
        endcase
    end

    assign dec_valid = head_valid;
    assign dec_pc    = head_pc;

endmodule

//--- source/deu_regfile.sv
`timescale 1ns/1ps

module deu_regfile #(
    parameter int DATA_W = 64
) (
    input  logic                                                        clk,
    input  logic                                                        rst_n,
    input  logic [deu_pipe_pkg::LANES-1:0]                              rf_we,
    input  logic [deu_pipe_pkg::LANES-1:0][deu_isa_pkg::ARF_SEL-1:0]    rf_waddr,
    input  logic [deu_pipe_pkg::LANES-1:0][DATA_W-1:0]                  result,
    input  logic [deu_pipe_pkg::LANES-1:0][deu_isa_pkg::ARF_SEL-1:0]    raddr0,
    input  logic [deu_pipe_pkg::LANES-1:0][deu_isa_pkg::ARF_SEL-1:0]    raddr1,
    output logic [deu_pipe_pkg::LANES-1:0][DATA_W-1:0]                  rdata0,
    output logic [deu_pipe_pkg::LANES-1:0][DATA_W-1:0]                  rdata1
);

    localparam int NREGS = 2 ** deu_isa_pkg::ARF_SEL;

    logic [DATA_W-1:0] regs [NREGS];

    // Later lane overrides on a shared address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int l = 0; l < deu_pipe_pkg::LANES; l++) begin
                if (rf_we[l] && rf_waddr[l] != '0) begin
                    regs[rf_waddr[l]] <= result[l];
                end
            end
        end
    end

    always_comb begin
        for (int l = 0; l < deu_pipe_pkg::LANES; l++) begin
            rdata0[l] = regs[raddr0[l]];   // r0 stays zero
            rdata1[l] = regs[raddr1[l]];
        end
    end

endmodule

//--- source/dispatch_reg.sv
`timescale 1ns/1ps

module dispatch_reg #(
    parameter int DATA_W = 64
) (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    issue_stall,
    input  logic [deu_pipe_pkg::LANES-1:0]                          dec_valid,
    input  deu_isa_pkg::deu_op_e [deu_pipe_pkg::LANES-1:0]          dec_op,
    input  logic [deu_pipe_pkg::LANES-1:0][deu_isa_pkg::PC_W-1:0]   dec_pc,
    input  logic [deu_pipe_pkg::LANES-1:0][DATA_W-1:0]              src0,
    input  logic [deu_pipe_pkg::LANES-1:0][DATA_W-1:0]              src1,
    output logic [deu_pipe_pkg::LANES-1:0]                          disp_valid,
    output deu_isa_pkg::deu_op_e [deu_pipe_pkg::LANES-1:0]          disp_op,
    output logic [deu_pipe_pkg::LANES-1:0][deu_isa_pkg::PC_W-1:0]   disp_pc,
    output logic [deu_pipe_pkg::LANES-1:0][DATA_W-1:0]              disp_src0,
    output logic [deu_pipe_pkg::LANES-1:0][DATA_W-1:0]              disp_src1
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            disp_valid <= '0;
        end else if (!issue_stall) begin
            disp_valid <= dec_valid;
        end
    end

    // Payload follows the same enable, held while stalled
    always_ff @(posedge clk) begin
        if (!issue_stall) begin
            disp_op   <= dec_op;
            disp_pc   <= dec_pc;
            disp_src0 <= src0;
            disp_src1 <= src1;
        end
    end

    // Younger lane never issues ahead of the older one
    a_lane_order: assert property (@(posedge clk) disable iff (!rst_n)
        disp_valid[deu_pipe_pkg::LANES-1] |-> disp_valid[0]);

endmodule

//--- source/deu_top.sv
`timescale 1ns/1ps

module deu_top #(
    parameter int DATA_W        = 64,
    parameter int BYPASS_STAGES = deu_pipe_pkg::NUM_BYPASS_STAGES
) (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic                                                    ifu_i0_valid,
    input  logic [deu_isa_pkg::PC_W-1:0]                            ifu_i0_pc,
    input  logic [deu_isa_pkg::INST_W-1:0]                          ifu_i0_inst,
    input  logic                                                    ifu_i1_valid,
    input  logic [deu_isa_pkg::PC_W-1:0]                            ifu_i1_pc,
    input  logic [deu_isa_pkg::INST_W-1:0]                          ifu_i1_inst,
    output logic                                                    ib2_val,
    output logic                                                    ib3_val,
    input  logic                                                    issue_stall,
    input  logic [BYPASS_STAGES-1:0][deu_pipe_pkg::LANES-1:0]       rf_we,
    input  logic [BYPASS_STAGES-1:0][deu_pipe_pkg::LANES-1:0][deu_isa_pkg::ARF_SEL-1:0] rf_waddr,
    input  logic [BYPASS_STAGES-1:0][deu_pipe_pkg::LANES-1:0][DATA_W-1:0] result,
    output logic [deu_pipe_pkg::LANES-1:0]                          disp_valid,
    output deu_isa_pkg::deu_op_e [deu_pipe_pkg::LANES-1:0]          disp_op,
    output logic [deu_pipe_pkg::LANES-1:0][deu_isa_pkg::PC_W-1:0]   disp_pc,
    output logic [deu_pipe_pkg::LANES-1:0][DATA_W-1:0]              disp_src0,
    output logic [deu_pipe_pkg::LANES-1:0][DATA_W-1:0]              disp_src1
);

    localparam int LANES = deu_pipe_pkg::LANES;

    logic [LANES-1:0]                              head_valid;
    logic [LANES-1:0][deu_isa_pkg::PC_W-1:0]       head_pc;
    logic [LANES-1:0][deu_isa_pkg::INST_W-1:0]     head_inst;
    logic [LANES-1:0][deu_isa_pkg::ARF_SEL-1:0]    raddr0;
    logic [LANES-1:0][deu_isa_pkg::ARF_SEL-1:0]    raddr1;
    logic [LANES-1:0][DATA_W-1:0]                  rdata0;
    logic [LANES-1:0][DATA_W-1:0]                  rdata1;
    logic [LANES-1:0]                              dec_valid;
    deu_isa_pkg::deu_op_e [LANES-1:0]              dec_op;
    logic [LANES-1:0][deu_isa_pkg::PC_W-1:0]       dec_pc;
    logic [LANES-1:0][DATA_W-1:0]                  src0;
    logic [LANES-1:0][DATA_W-1:0]                  src1;

    inst_queue inst_queue_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_stall  (issue_stall),
        .ifu_i0_valid (ifu_i0_valid),
        .ifu_i0_pc    (ifu_i0_pc),
        .ifu_i0_inst  (ifu_i0_inst),
        .ifu_i1_valid (ifu_i1_valid),
        .ifu_i1_pc    (ifu_i1_pc),
        .ifu_i1_inst  (ifu_i1_inst),
        .ib2_val      (ib2_val),
        .ib3_val      (ib3_val),
        .head_valid   (head_valid),
        .head_pc      (head_pc),
        .head_inst    (head_inst)
    );

    ////////////////////////////////////////////////
    // Issue lanes
    ////////////////////////////////////////////////

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        issue_lane #(.DATA_W(DATA_W), .BYPASS_STAGES(BYPASS_STAGES)) issue_lane_i (
            .head_valid (head_valid[l]),
            .head_pc    (head_pc[l]),
            .head_inst  (head_inst[l]),
            .rdata0     (rdata0[l]),
            .rdata1     (rdata1[l]),
            .rf_we      (rf_we),
            .rf_waddr   (rf_waddr),
            .result     (result),
            .raddr0     (raddr0[l]),
            .raddr1     (raddr1[l]),
            .dec_valid  (dec_valid[l]),
            .dec_op     (dec_op[l]),
            .dec_pc     (dec_pc[l]),
            .src0       (src0[l]),
            .src1       (src1[l])
        );
    end

    // Last bypass stage is wb
    deu_regfile #(.DATA_W(DATA_W)) deu_regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rf_we    (rf_we[BYPASS_STAGES-1]),
        .rf_waddr (rf_waddr[BYPASS_STAGES-1]),
        .result   (result[BYPASS_STAGES-1]),
        .raddr0   (raddr0),
        .raddr1   (raddr1),
        .rdata0   (rdata0),
        .rdata1   (rdata1)
    );

    dispatch_reg #(.DATA_W(DATA_W)) dispatch_reg_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_stall (issue_stall),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_pc      (dec_pc),
        .src0        (src0),
        .src1        (src1),
        .disp_valid  (disp_valid),
        .disp_op     (disp_op),
        .disp_pc     (disp_pc),
        .disp_src0   (disp_src0),
        .disp_src1   (disp_src1)
    );

endmodule

//--- testbench/deu_tb_clock.sv
`timescale 1ns/1ps

module deu_tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // Released on the edge that ends the last reset cycle
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- testbench/deu_tb.sv
`timescale 1ns/1ps

module deu_tb;

    localparam int DATA_W         = 64;
    localparam int STAGES         = deu_pipe_pkg::NUM_BYPASS_STAGES;
    localparam int LANES          = deu_pipe_pkg::LANES;
    localparam int SEL_W          = deu_isa_pkg::ARF_SEL;
    localparam int RAND_PHASES    = 8;
    localparam int RAND_INSTS     = 50;
    localparam int TIMEOUT_CYCLES = 1000 + 10 * RAND_PHASES * RAND_INSTS;  // Directed part fits in 1000

    typedef struct packed {
        logic [63:0] pc;
        logic [31:0] inst;
    } fetch_t;

    typedef struct packed {
        logic [63:0] pc;
        logic [5:0]  op;
        logic [63:0] src0;
        logic [63:0] src1;
    } expect_t;

    logic                                       clk;
    logic                                       rst_n;
    logic                                       issue_stall;
    logic                                       ifu_i0_valid;
    logic [63:0]                                ifu_i0_pc;
    logic [31:0]                                ifu_i0_inst;
    logic                                       ifu_i1_valid;
    logic [63:0]                                ifu_i1_pc;
    logic [31:0]                                ifu_i1_inst;
    logic                                       ib2_val;
    logic                                       ib3_val;
    logic [STAGES-1:0][LANES-1:0]               rf_we;
    logic [STAGES-1:0][LANES-1:0][SEL_W-1:0]    rf_waddr;
    logic [STAGES-1:0][LANES-1:0][DATA_W-1:0]   result;
    logic [LANES-1:0]                           disp_valid;
    deu_isa_pkg::deu_op_e [LANES-1:0]           disp_op;
    logic [LANES-1:0][63:0]                     disp_pc;
    logic [LANES-1:0][DATA_W-1:0]               disp_src0;
    logic [LANES-1:0][DATA_W-1:0]               disp_src1;

    fetch_t             prog_q[$];
    expect_t            exp_q[$];
    logic [31:0][63:0]  shadow_rf;      // Architectural state as seen by wb
    logic [63:0]        pc_next;
    int                 occ;            // Queue entries after the last edge
    int                 cycles = 0;

    deu_tb_clock #(.PERIOD(10), .RESET_CYCLES(3)) clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    deu_top #(.DATA_W(DATA_W), .BYPASS_STAGES(STAGES)) deu_top_i (.*);

    ////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////

    function automatic logic [63:0] read_src(
        input logic [SEL_W-1:0]                          r,
        input logic [STAGES-1:0][LANES-1:0]              we,
        input logic [STAGES-1:0][LANES-1:0][SEL_W-1:0]   waddr,
        input logic [STAGES-1:0][LANES-1:0][DATA_W-1:0]  res,
        input logic [31:0][63:0]                         regs
    );
        logic [63:0] v;
        logic        found;
        v     = regs[r];
        found = 1'b0;
        for (int s = 0; s < STAGES; s++) begin
            for (int l = LANES - 1; l >= 0; l--) begin     // Lane 1 is younger
                if (!found && we[s][l] && waddr[s][l] == r) begin
                    v     = res[s][l];
                    found = 1'b1;
                end
            end
        end
        if (r == '0) begin
            v = '0;
        end
        return v;
    endfunction

    function automatic expect_t ref_decode(
        input logic [63:0]                               pc,
        input logic [31:0]                               inst,
        input logic [STAGES-1:0][LANES-1:0]              we,
        input logic [STAGES-1:0][LANES-1:0][SEL_W-1:0]   waddr,
        input logic [STAGES-1:0][LANES-1:0][DATA_W-1:0]  res,
        input logic [31:0][63:0]                         regs
    );
        expect_t     e;
        logic [63:0] imm;
        imm    = {{52{inst[21]}}, inst[21:10]};
        e.pc   = pc;
        e.op   = 6'd0;
        e.src0 = '0;
        e.src1 = '0;
        case (inst[31:26])
            6'd1: begin
                e.op   = 6'd1;
                e.src0 = read_src(inst[9:5], we, waddr, res, regs);
                e.src1 = read_src(inst[14:10], we, waddr, res, regs);
            end
            6'd2: begin
                e.op   = 6'd2;
                e.src0 = read_src(inst[9:5], we, waddr, res, regs);
                e.src1 = imm;
            end
            6'd3: begin
                e.op   = 6'd3;
                e.src0 = pc;
                e.src1 = 64'd4;
            end
            6'd4: begin
                e.op   = 6'd4;
                e.src0 = pc;
                e.src1 = imm;
            end
            default: ;
        endcase
        return e;
    endfunction

    function automatic logic [31:0] enc_rr(input logic [5:0] opc, input logic [4:0] rj,
                                           input logic [4:0] rk);
        return {opc, 11'd0, rk, rj, 5'd1};
    endfunction

    function automatic logic [31:0] enc_ri(input logic [5:0] opc, input logic [4:0] rj,
                                           input logic [11:0] imm);
        return {opc, 4'd0, imm, rj, 5'd1};
    endfunction

    ////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_lane(input int l);
        expect_t e;
        if (exp_q.size() == 0) begin
            fail_run($sformatf("lane %0d dispatched an instruction that was never fetched", l));
        end else begin
            e = exp_q.pop_front();
            check_value($sformatf("disp_pc[%0d]", l), disp_pc[l], e.pc);
            check_value($sformatf("disp_op[%0d]", l), 64'(disp_op[l]), 64'(e.op));
            check_value($sformatf("disp_src0[%0d]", l), disp_src0[l], e.src0);
            check_value($sformatf("disp_src1[%0d]", l), disp_src1[l], e.src1);
        end
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_value("ib2_val", 64'(ib2_val), 64'(occ > 2));
            check_value("ib3_val", 64'(ib3_val), 64'(occ > 3));
            if (!issue_stall) begin
                for (int l = 0; l < LANES; l++) begin
                    if (disp_valid[l]) begin
                        compare_lane(l);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: the run did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
        end
    end

    ////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////

    task automatic tick();
        int pops;
        @(posedge clk);
        pops = 0;
        if (!issue_stall) begin
            pops = (occ > LANES) ? LANES : occ;
        end
        occ = occ - pops + int'(ifu_i0_valid) + int'(ifu_i1_valid);
    endtask

    task automatic add_inst(input logic [31:0] inst);
        fetch_t f;
        f.pc    = pc_next;
        f.inst  = inst;
        prog_q.push_back(f);
        pc_next = pc_next + 64'd4;
    endtask

    task automatic drive_cycle(input int n, input logic stall);
        fetch_t f;
        issue_stall  <= stall;
        ifu_i0_valid <= (n > 0);
        ifu_i1_valid <= (n > 1);
        if (n > 0) begin
            f = prog_q.pop_front();
            ifu_i0_pc   <= f.pc;
            ifu_i0_inst <= f.inst;
            exp_q.push_back(ref_decode(f.pc, f.inst, rf_we, rf_waddr, result, shadow_rf));
        end
        if (n > 1) begin
            f = prog_q.pop_front();
            ifu_i1_pc   <= f.pc;
            ifu_i1_inst <= f.inst;
            exp_q.push_back(ref_decode(f.pc, f.inst, rf_we, rf_waddr, result, shadow_rf));
        end
        tick();
    endtask

    task automatic set_producers(input int we_pct, input logic [SEL_W-1:0] ra,
                                 input logic [SEL_W-1:0] rb);
        for (int s = 0; s < STAGES; s++) begin
            for (int l = 0; l < LANES; l++) begin
                rf_we[s][l]    <= ($urandom_range(99) < we_pct);
                rf_waddr[s][l] <= $urandom_range(1) ? ra : rb;
                result[s][l]   <= {$urandom, $urandom};
            end
        end
    endtask

    // Streams prog_q, drains, then retires the wb writes into the shadow
    task automatic run_phase(input int stall_pct, input bit mixed);
        int room;
        int n;
        drive_cycle(0, 1'b0);
        while (prog_q.size() > 0) begin
            room = (occ <= 2) ? 2 : ((occ <= 3) ? 1 : 0);
            n    = mixed ? int'($urandom_range(2)) : 2;
            if (n > room) begin
                n = room;
            end
            if (n > prog_q.size()) begin
                n = prog_q.size();
            end
            drive_cycle(n, mixed && ($urandom_range(99) < stall_pct));
        end
        while (exp_q.size() > 0) begin
            drive_cycle(0, 1'b0);
        end
        for (int l = 0; l < LANES; l++) begin
            if (rf_we[STAGES-1][l] && rf_waddr[STAGES-1][l] != '0) begin
                shadow_rf[rf_waddr[STAGES-1][l]] = result[STAGES-1][l];
            end
        end
        rf_we <= '0;
        drive_cycle(0, 1'b0);
    endtask

    initial begin
        void'($urandom(71));
        issue_stall  = 1'b0;
        ifu_i0_valid = 1'b0;
        ifu_i0_pc    = '0;
        ifu_i0_inst  = '0;
        ifu_i1_valid = 1'b0;
        ifu_i1_pc    = '0;
        ifu_i1_inst  = '0;
        rf_we        = '0;
        rf_waddr     = '0;
        result       = '0;
        shadow_rf    = '0;
        occ          = 0;
        pc_next      = 64'h0000_0000_0001_0000;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
        end

        // Reset state, then single push latency
        @(negedge clk);
        check_value("disp_valid", 64'(disp_valid), 64'd0);
        check_value("ib2_val", 64'(ib2_val), 64'd0);
        check_value("ib3_val", 64'(ib3_val), 64'd0);
        tick();
        add_inst(enc_ri(6'd4, 5'd0, 12'h123));
        drive_cycle(1, 1'b0);               // Push taken here
        ifu_i0_valid <= 1'b0;
        @(negedge clk);
        check_value("disp_valid", 64'(disp_valid), 64'd0);
        tick();
        @(negedge clk);
        check_value("disp_valid", 64'(disp_valid), 64'd1);
        tick();

        // Fill registers through wb with r31's partner write aimed at r0
        for (int r = 1; r < 32; r += 2) begin
            rf_we[STAGES-1]    <= 2'b11;
            rf_waddr[STAGES-1] <= {5'((r + 1) % 32), 5'(r)};
            result[STAGES-1]   <= {{$urandom, $urandom}, {$urandom, $urandom}};
            run_phase(0, 1'b0);
        end
        rf_we[STAGES-1]    <= 2'b11;       // Lane 1 wins the shared address
        rf_waddr[STAGES-1] <= {5'd5, 5'd5};
        result[STAGES-1]   <= {{$urandom, $urandom}, {$urandom, $urandom}};
        run_phase(0, 1'b0);

        // Plain register reads and sign-extended immediates
        for (int i = 0; i < 12; i++) begin
            add_inst(enc_rr(6'd1, 5'(i + 1), 5'(31 - i)));
            add_inst(enc_ri(6'd2, 5'(i + 20), 12'(i * 341)));
        end
        run_phase(0, 1'b0);

        // Bypass priority on r7 and r9
        for (int p = 0; p < 6; p++) begin
            set_producers((p == 0) ? 100 : 50, 5'd7, 5'd9);
            for (int i = 0; i < 4; i++) begin
                add_inst(enc_rr(6'd1, 5'd7, 5'd9));
                add_inst(enc_rr(6'd1, 5'd9, 5'd3));
                add_inst(enc_ri(6'd2, 5'd7, 12'hf00));
            end
            run_phase(0, 1'b0);
        end

        // r0 ignores producers aimed at it
        set_producers(100, 5'd0, 5'd0);
        add_inst(enc_rr(6'd1, 5'd0, 5'd0));
        add_inst(enc_ri(6'd2, 5'd0, 12'hfff));
        add_inst(enc_rr(6'd1, 5'd0, 5'd2));
        run_phase(0, 1'b0);

        // PC based forms and unknown opcodes
        add_inst(enc_ri(6'd3, 5'd4, 12'h7ff));
        add_inst(enc_ri(6'd4, 5'd4, 12'h800));
        add_inst(enc_ri(6'd4, 5'd4, 12'h001));
        add_inst(enc_rr(6'd5, 5'd4, 5'd6));
        add_inst(enc_rr(6'd63, 5'd4, 5'd6));
        add_inst(enc_rr(6'd0, 5'd4, 5'd6));
        add_inst(enc_rr(6'd42, 5'd4, 5'd6));
        run_phase(0, 1'b0);

        // Random traffic with stalls and mixed push widths
        for (int p = 0; p < RAND_PHASES; p++) begin
            set_producers(40, 5'($urandom), 5'($urandom));
            for (int i = 0; i < RAND_INSTS; i++) begin
                add_inst({6'($urandom_range(7)), 26'($urandom)});
            end
            run_phase(30, 1'b1);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

//--- deu_top.f
common/deu_isa_pkg.sv
common/deu_pipe_pkg.sv
inst_queue/inst_queue.sv
issue_lane/bypass_select.sv
issue_lane/issue_lane.sv
source/deu_regfile.sv
source/dispatch_reg.sv
source/deu_top.sv
testbench/deu_tb_clock.sv
testbench/deu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = deu_tb
FILELIST  = deu_top.f

.PHONY: sim clean

# Pass only when the testbench prints its pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
